// ==== hdl/fetch_pkg.sv ====
// fetch package with shared widths, reset pc, response codes and fetch FSM states
package fetch_pkg;

	// data and address width
	localparam int XLEN = 32;

	// first fetch address after reset
	localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

	// pc step per instruction
	localparam logic [XLEN-1:0] INST_BYTES = 32'd4;

	// read response codes, anything but okay is a fault
	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// read FSM of the fetch unit
	typedef enum logic [2:0] {
		IDLE         = 3'd0,
		WAIT_ARREADY = 3'd1,
		WAIT_RVALID  = 3'd2
	} fetch_state_t;

endpackage

// ==== hdl/isram.sv ====
// instruction SRAM model with address and response channels, fixed read latency and a load port
`timescale 1ns/1ps
module isram
	import fetch_pkg::*;
#(
	parameter int MEM_WORDS  = 64,
	parameter int RD_LATENCY = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  logic [XLEN-1:0] araddr,
	input  logic            arvalid,
	output logic            arready,
	output logic [XLEN-1:0] rdata,
	output logic [1:0]      rresp,
	output logic            rvalid,
	input  logic            rready,
	input  logic            load_en,
	input  logic [XLEN-1:0] load_addr,
	input  logic [XLEN-1:0] load_data
);

	localparam int AW = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
	localparam int CW = $clog2(RD_LATENCY + 1);

	logic [XLEN-1:0] mem [MEM_WORDS];
	logic            busy;
	logic [CW-1:0]   cnt;
	logic            ar_ok;
	logic            load_ok;
	logic [AW-1:0]   ar_idx;
	logic [AW-1:0]   load_idx;

	// word aligned and inside the array
	assign ar_ok   = (araddr[1:0] == 2'b00) && ((araddr >> 2) < XLEN'(MEM_WORDS));
	assign load_ok = (load_addr[1:0] == 2'b00) && ((load_addr >> 2) < XLEN'(MEM_WORDS));
	assign ar_idx   = araddr[AW+1:2];
	assign load_idx = load_addr[AW+1:2];

	assign arready = !busy;
	assign rvalid  = busy && (cnt == '0);

	always_ff @(posedge clk) begin
		if (load_en && load_ok)
			mem[load_idx] <= load_data;
	end

	// single outstanding read, counted down from the address handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			cnt  <= '0;
		end else if (arvalid && arready) begin
			busy <= 1'b1;
			cnt  <= CW'(RD_LATENCY - 1);
		end else if (busy) begin
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			else if (rready)
				busy <= 1'b0;
		end
	end

	// response payload sampled at the address handshake
	always_ff @(posedge clk) begin
		if (arvalid && arready) begin
			if (ar_ok) begin
				rdata <= mem[ar_idx];
				rresp <= RESP_OKAY;
			end else begin
				rdata <= '0;
				rresp <= RESP_SLVERR;
			end
		end
	end

	r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid);

endmodule

// ==== hdl/fetch_queue.sv ====
// fetch queue buffering fetched entries, tracking read reservations and decode credits
`timescale 1ns/1ps
module fetch_queue
	import fetch_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4,
	parameter int DEC_CREDITS = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            push,
	input  logic [XLEN-1:0] push_pc,
	input  logic [XLEN-1:0] push_inst,
	input  logic            push_fault,
	input  logic            reserve,
	input  logic            release_slot,
	input  logic            flush,
	output logic            space,
	output logic            dec_valid,
	output logic [XLEN-1:0] dec_pc,
	output logic [XLEN-1:0] dec_inst,
	output logic            dec_fault,
	input  logic            dec_credit
);

	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CW = $clog2(QUEUE_DEPTH + 1);
	localparam int KW = $clog2(DEC_CREDITS + 1);

	logic [XLEN-1:0] pc_mem [QUEUE_DEPTH];
	logic [XLEN-1:0] inst_mem [QUEUE_DEPTH];
	logic            fault_mem [QUEUE_DEPTH];
	logic [PW-1:0]   rd_ptr;
	logic [PW-1:0]   wr_ptr;
	logic [CW-1:0]   count;
	logic [CW-1:0]   resv;
	logic [CW:0]     used;
	logic [KW-1:0]   credits;
	logic            pop;

	function automatic logic [PW-1:0] ptr_next(input logic [PW-1:0] p);
		if (p == PW'(QUEUE_DEPTH - 1))
			return '0;
		return p + 1'b1;
	endfunction

	// reads in flight already own a slot
	assign used  = count + resv;
	assign space = used < (CW+1)'(QUEUE_DEPTH);

	assign dec_valid = (count != '0) && (credits != '0);
	assign pop       = dec_valid;
	assign dec_pc    = pc_mem[rd_ptr];
	assign dec_inst  = inst_mem[rd_ptr];
	assign dec_fault = fault_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push && !flush) begin
			pc_mem[wr_ptr]    <= push_pc;
			inst_mem[wr_ptr]  <= push_inst;
			fault_mem[wr_ptr] <= push_fault;
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_next(wr_ptr);
			if (pop)
				rd_ptr <= ptr_next(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// flush leaves these alone, the dropped reads come back as releases
	always_ff @(posedge clk) begin
		if (rst) begin
			resv <= '0;
		end else begin
			case ({reserve, push || release_slot})
				2'b10:   resv <= resv + 1'b1;
				2'b01:   resv <= resv - 1'b1;
				default: resv <= resv;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= KW'(DEC_CREDITS);
		end else begin
			case ({pop, dec_credit})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= KW'(DEC_CREDITS));

	push_reserved: assert property (@(posedge clk) disable iff (rst)
		push |-> resv != '0);

endmodule

// ==== hdl/fetch_unit.sv ====
// fetch unit holding the pc, capturing redirects and issuing one instruction read at a time
`timescale 1ns/1ps
module fetch_unit
	import fetch_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect_valid,
	input  logic [XLEN-1:0] redirect_pc,
	output logic [XLEN-1:0] araddr,
	output logic            arvalid,
	input  logic            arready,
	input  logic [XLEN-1:0] rdata,
	input  logic [1:0]      rresp,
	input  logic            rvalid,
	output logic            rready,
	input  logic            space,
	output logic            reserve,
	output logic            release_slot,
	output logic            push,
	output logic [XLEN-1:0] push_pc,
	output logic [XLEN-1:0] push_inst,
	output logic            push_fault,
	output logic            flush
);

	fetch_state_t    state;
	logic [XLEN-1:0] pc;
	logic            epoch;
	logic            req_epoch;
	logic            halted;
	logic            redir_pend;
	logic [XLEN-1:0] redir_pc_q;
	logic            accept;
	logic            ar_fire;
	logic            r_fire;
	logic            stale;

	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid && rready;

	// an address already on the bus must stay put, so wait that one out
	assign accept = redir_pend && (state != WAIT_ARREADY);

	// response from an older path, or one overtaken by this cycle's redirect
	assign stale = accept || (req_epoch != epoch);

	assign araddr  = pc;
	assign arvalid = (state == WAIT_ARREADY);
	assign rready  = (state == WAIT_RVALID);
	assign reserve = ar_fire;

	// read FSM
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (space && !halted && !redir_pend)
						state <= WAIT_ARREADY;
				end
				WAIT_ARREADY: begin
					if (arready)
						state <= WAIT_RVALID;
				end
				WAIT_RVALID: begin
					if (rvalid)
						state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// hold the latest redirect until it can be applied
	always_ff @(posedge clk) begin
		if (rst)
			redir_pend <= 1'b0;
		else if (redirect_valid)
			redir_pend <= 1'b1;
		else if (accept)
			redir_pend <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (redirect_valid)
			redir_pc_q <= redirect_pc;
	end

	// pc advances only once its word has come back clean
	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= RESET_PC;
			epoch  <= 1'b0;
			halted <= 1'b0;
		end else if (accept) begin
			pc     <= redir_pc_q;
			epoch  <= ~epoch;
			halted <= 1'b0;
		end else if (r_fire && !stale) begin
			if (rresp != RESP_OKAY)
				halted <= 1'b1;
			else
				pc <= pc + INST_BYTES;
		end
	end

	// tag each read with the path it was issued on
	always_ff @(posedge clk) begin
		if (rst)
			req_epoch <= 1'b0;
		else if (ar_fire)
			req_epoch <= epoch;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			push         <= 1'b0;
			release_slot <= 1'b0;
			flush        <= 1'b0;
		end else begin
			push         <= r_fire && !stale;
			release_slot <= r_fire && stale;
			flush        <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (r_fire) begin
			push_pc    <= pc;
			push_inst  <= rdata;
			push_fault <= (rresp != RESP_OKAY);
		end
	end

	ar_stable: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(araddr));

	state_legal: assert property (@(posedge clk) disable iff (rst)
		state inside {IDLE, WAIT_ARREADY, WAIT_RVALID});

endmodule

// ==== hdl/fetch_top.sv ====
// fetch subsystem top connecting the fetch unit, instruction SRAM and fetch queue
`timescale 1ns/1ps
module fetch_top
	import fetch_pkg::*;
#(
	parameter int MEM_WORDS   = 64,
	parameter int RD_LATENCY  = 2,
	parameter int QUEUE_DEPTH = 4,
	parameter int DEC_CREDITS = 2
) (
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect_valid,
	input  logic [XLEN-1:0] redirect_pc,
	input  logic            load_en,
	input  logic [XLEN-1:0] load_addr,
	input  logic [XLEN-1:0] load_data,
	output logic            dec_valid,
	output logic [XLEN-1:0] dec_pc,
	output logic [XLEN-1:0] dec_inst,
	output logic            dec_fault,
	input  logic            dec_credit
);

	// read-address channel
	logic [XLEN-1:0] araddr;
	logic            arvalid;
	logic            arready;

	// read-response channel
	logic [XLEN-1:0] rdata;
	logic [1:0]      rresp;
	logic            rvalid;
	logic            rready;

	// fetch unit to queue
	logic            space;
	logic            reserve;
	logic            release_slot;
	logic            push;
	logic [XLEN-1:0] push_pc;
	logic [XLEN-1:0] push_inst;
	logic            push_fault;
	logic            flush;

	fetch_unit u_fetch_unit (
		.clk            (clk),
		.rst            (rst),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.araddr         (araddr),
		.arvalid        (arvalid),
		.arready        (arready),
		.rdata          (rdata),
		.rresp          (rresp),
		.rvalid         (rvalid),
		.rready         (rready),
		.space          (space),
		.reserve        (reserve),
		.release_slot   (release_slot),
		.push           (push),
		.push_pc        (push_pc),
		.push_inst      (push_inst),
		.push_fault     (push_fault),
		.flush          (flush)
	);

	isram #(
		.MEM_WORDS  (MEM_WORDS),
		.RD_LATENCY (RD_LATENCY)
	) u_isram (
		.clk       (clk),
		.rst       (rst),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data)
	);

	fetch_queue #(
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.DEC_CREDITS (DEC_CREDITS)
	) u_fetch_queue (
		.clk          (clk),
		.rst          (rst),
		.push         (push),
		.push_pc      (push_pc),
		.push_inst    (push_inst),
		.push_fault   (push_fault),
		.reserve      (reserve),
		.release_slot (release_slot),
		.flush        (flush),
		.space        (space),
		.dec_valid    (dec_valid),
		.dec_pc       (dec_pc),
		.dec_inst     (dec_inst),
		.dec_fault    (dec_fault),
		.dec_credit   (dec_credit)
	);

endmodule

// ==== sim/fetch_tb.sv ====
// testbench for the fetch subsystem driving file stimulus and checking the decode stream
`timescale 1ns/1ps
module fetch_tb
	import fetch_pkg::*;
();

	localparam int MEM_WORDS   = 64;
	localparam int RD_LATENCY  = 2;
	localparam int QUEUE_DEPTH = 4;
	localparam int DEC_CREDITS = 2;
	localparam int CYCLES_PER_ENTRY = 40;

	logic            clk;
	logic            rst;
	logic            redirect_valid;
	logic [XLEN-1:0] redirect_pc;
	logic            load_en;
	logic [XLEN-1:0] load_addr;
	logic [XLEN-1:0] load_data;
	logic            dec_valid;
	logic [XLEN-1:0] dec_pc;
	logic [XLEN-1:0] dec_inst;
	logic            dec_fault;
	logic            dec_credit;

	// stimulus from the input file
	logic [XLEN-1:0] mem_img [logic [XLEN-1:0]];
	logic [XLEN-1:0] img_addr_q[$];
	logic [XLEN-1:0] img_data_q[$];
	int              redir_cyc_q[$];
	logic [XLEN-1:0] redir_target_q[$];
	int              n_expected;
	int              wd_limit;

	// reference model state
	logic [XLEN-1:0] exp_pc;
	logic            pend;
	logic [XLEN-1:0] pend_target;
	logic            halted;
	int              checked;
	int              pops;
	int              returned;
	int              due_q[$];
	int              redir_idx;
	int              cyc;
	int              seed;
	logic            running;

	fetch_top #(
		.MEM_WORDS   (MEM_WORDS),
		.RD_LATENCY  (RD_LATENCY),
		.QUEUE_DEPTH (QUEUE_DEPTH),
		.DEC_CREDITS (DEC_CREDITS)
	) DUT (
		.clk            (clk),
		.rst            (rst),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc),
		.load_en        (load_en),
		.load_addr      (load_addr),
		.load_data      (load_data),
		.dec_valid      (dec_valid),
		.dec_pc         (dec_pc),
		.dec_inst       (dec_inst),
		.dec_fault      (dec_fault),
		.dec_credit     (dec_credit)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic read_input();
		int              fd;
		int              c;
		string           line;
		byte             tag;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		fd = $fopen("sim/fetch_input.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open the stimulus file sim/fetch_input.txt");
		n_expected = 0;
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			case (line[0])
				"m": begin
					void'($sscanf(line, "%c %h %h", tag, a, b));
					img_addr_q.push_back(a);
					img_data_q.push_back(b);
					mem_img[a] = b;
				end
				"r": begin
					void'($sscanf(line, "%c %d %h", tag, c, a));
					redir_cyc_q.push_back(c);
					redir_target_q.push_back(a);
				end
				"n": void'($sscanf(line, "%c %d", tag, n_expected));
				default: stop_on_error("the stimulus file holds a line of unknown kind");
			endcase
		end
		$fclose(fd);
		if (n_expected <= 0)
			stop_on_error("the stimulus file gives no entry count");
	endtask

	// one decode entry against the reference pc and memory image
	task automatic check_entry();
		logic [XLEN-1:0] exp_inst;
		logic            exp_fault;
		if (pend && dec_pc === pend_target) begin
			exp_pc = pend_target;
			pend   = 1'b0;
			halted = 1'b0;
		end
		assert (!halted)
			else stop_on_error("an entry reached decode after a fault and before any redirect");
		assert (dec_pc === exp_pc)
			else stop_on_error($sformatf("[ERROR] dec_pc expected %h actual %h", exp_pc, dec_pc));
		exp_fault = (exp_pc[1:0] != 2'b00) || ((exp_pc >> 2) >= XLEN'(MEM_WORDS));
		assert (dec_fault === exp_fault)
			else stop_on_error($sformatf("[ERROR] dec_fault expected %h actual %h",
				exp_fault, dec_fault));
		if (exp_fault) begin
			assert (dec_inst === '0)
				else stop_on_error($sformatf("[ERROR] dec_inst expected %h actual %h",
					32'h0, dec_inst));
			halted = 1'b1;
		end else begin
			assert (mem_img.exists(exp_pc))
				else stop_on_error("the stream reached a word that the image does not load");
			exp_inst = mem_img[exp_pc];
			assert (dec_inst === exp_inst)
				else stop_on_error($sformatf("[ERROR] dec_inst expected %h actual %h",
					exp_inst, dec_inst));
			exp_pc = exp_pc + INST_BYTES;
		end
		checked++;
	endtask

	// outputs are sampled here, half a cycle after they settle
	task automatic cycle_step();
		dec_credit     = 1'b0;
		redirect_valid = 1'b0;
		assert (!$isunknown(dec_valid))
			else stop_on_error("dec_valid is unknown after reset");
		if (dec_valid) begin
			pops++;
			assert (pops <= DEC_CREDITS + returned)
				else stop_on_error($sformatf("[ERROR] dec_valid pops expected at most %h actual %h",
					DEC_CREDITS + returned, pops));
			check_entry();
			due_q.push_back(cyc + int'({$random(seed)} % 4));
		end
		if (redir_idx < redir_cyc_q.size() && redir_cyc_q[redir_idx] == cyc) begin
			redirect_valid = 1'b1;
			redirect_pc    = redir_target_q[redir_idx];
			pend           = 1'b1;
			pend_target    = redir_target_q[redir_idx];
			redir_idx++;
		end
		if (due_q.size() > 0 && due_q[0] <= cyc) begin
			dec_credit = 1'b1;
			void'(due_q.pop_front());
			returned++;
		end
	endtask

	initial begin
		int i;
		rst            = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc    = '0;
		load_en        = 1'b0;
		load_addr      = '0;
		load_data      = '0;
		dec_credit     = 1'b0;
		running        = 1'b0;
		seed           = 83140;
		exp_pc         = RESET_PC;
		pend           = 1'b0;
		pend_target    = '0;
		halted         = 1'b0;
		checked        = 0;
		pops           = 0;
		returned       = 0;
		redir_idx      = 0;
		cyc            = 0;
		read_input();
		wd_limit = CYCLES_PER_ENTRY * n_expected;
		if (redir_cyc_q.size() > 0)
			wd_limit = wd_limit + redir_cyc_q[redir_cyc_q.size() - 1];
		// image goes in while the DUT sits in reset
		for (i = 0; i < img_addr_q.size(); i++) begin
			@(negedge clk);
			load_en   = 1'b1;
			load_addr = img_addr_q[i];
			load_data = img_data_q[i];
		end
		@(negedge clk);
		load_en = 1'b0;
		repeat (10) @(negedge clk);
		rst     = 1'b0;
		running = 1'b1;
		assert (dec_valid === 1'b0)
			else stop_on_error($sformatf("[ERROR] dec_valid expected %h actual %h", 1'b0, dec_valid));
		while (checked < n_expected) begin
			@(negedge clk);
			cyc++;
			cycle_step();
		end
		if (checked == n_expected) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("TESTS FAILED");
			$fatal(1);
		end
	end

	// watchdog
	initial begin
		wait (running);
		repeat (wd_limit) @(posedge clk);
		stop_on_error($sformatf("decode output stalled with %0d of %0d entries checked",
			checked, n_expected));
	end

endmodule

// ==== filelist.f ====
hdl/fetch_pkg.sv
hdl/isram.sv
hdl/fetch_queue.sv
hdl/fetch_unit.sv
hdl/fetch_top.sv
sim/fetch_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = fetch_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== sim/fetch_input.txt ====
# m <addr> <word> loads one memory word (both hex)
# r <cycle> <target> redirects after that many cycles out of reset (cycle decimal, target hex)
# n <count> sets the number of decode entries to check
m 00000000 00000013
m 00000004 00100093
m 00000008 00200113
m 0000000c 002081b3
m 00000010 40110233
m 00000014 0041f2b3
m 00000018 00326333
m 0000001c 005303b3
m 00000020 00738463
m 00000024 0080006f
m 00000028 00a00513
m 0000002c 00b00593
m 00000030 00c50633
m 00000034 00d00693
m 00000038 00e00713
m 0000003c 00f707b3
m 00000080 10000013
m 00000084 10100093
m 00000088 10200113
m 0000008c 10308193
m 00000090 10410213
m 00000094 10518293
m 00000098 10620313
m 0000009c 10728393
m 000000a0 10830413
m 000000a4 10938493
m 000000a8 10a40513
m 000000ac 10b48593
m 000000f0 f0000013
m 000000f4 f0100093
m 000000f8 f0200113
m 000000fc f0300193
r 30 00000080
r 70 000000f0
r 120 00000020
n 27
